// File: list.f
src/axis_out_pkg.sv
src/axis_out_csrs.sv
src/axis_out_fifo.sv
src/axis_out_reader.sv
src/axis_out.sv
testbench/axis_out_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the axis_out testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=axis_out_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv -f list.f --top-module "$TOP" \
   -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: testbench/axis_out_tb.sv
// ****************************************************************************
// axis_out testbench
// table driven CPU and stream frames checked against a byte queue model
// ****************************************************************************
`timescale 1ns/100ps

module axis_out_tb;

   localparam int ROWS  = 8;
   localparam int LIMIT = 200 * ROWS + 100;

   typedef struct packed {
      logic       mode;
      logic [7:0] nwords;
      logic [3:0] thresh;
      logic [3:0] words;
      logic       stall;
      logic [7:0] cut;
   } row_t;

   logic                                 clk;
   logic                                 rst;
   logic [axis_out_pkg::CSR_AW-1:0]      csr_addr;
   logic [31:0]                          csr_wdata;
   logic                                 csr_we;
   logic [31:0]                          csr_rdata;
   logic [31:0]                          sys_tdata;
   logic                                 sys_tvalid;
   logic                                 sys_tready;
   logic [axis_out_pkg::TDATA_W-1:0]     tdata;
   logic                                 tvalid;
   logic                                 tready;
   logic                                 tlast;
   logic                                 irq;
   row_t                                 rows [ROWS];
   logic [31:0]                          data_tab [ROWS][10];
   logic [31:0]                          words_q [$];
   logic [7:0]                           bytes_q [$];
   int                                   errors = 0;
   int                                   checks = 0;
   int                                   cycles;

   axis_out DUT (
      .clk_i(clk), .rst_i(rst),
      .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata), .csr_we_i(csr_we),
      .csr_rdata_o(csr_rdata),
      .sys_tdata_i(sys_tdata), .sys_tvalid_i(sys_tvalid), .sys_tready_o(sys_tready),
      .axis_tdata_o(tdata), .axis_tvalid_o(tvalid), .axis_tready_i(tready),
      .axis_tlast_o(tlast), .interrupt_o(irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic csr_write(input logic [3:0] addr, input logic [31:0] value);
      @(posedge clk);
      csr_we    <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= value;
      @(posedge clk);
      csr_we   <= 1'b0;
      csr_addr <= axis_out_pkg::ADDR_STATUS;
   endtask

   task automatic check_status(input int level, input logic [3:0] thresh);
      @(posedge clk);
      check("status.full", 32'(csr_rdata[0]), 32'(level == 8));
      check("status.empty", 32'(csr_rdata[1]), 32'(level == 0));
      check("status.level", 32'(csr_rdata[8 +: axis_out_pkg::LEVEL_W]), 32'(level));
      check("interrupt_o", 32'(irq), 32'(level <= int'(thresh)));
   endtask

   task automatic restart(input row_t r);
      csr_write(axis_out_pkg::ADDR_CTRL, 32'h1);
      csr_write(axis_out_pkg::ADDR_NWORDS, {24'd0, r.nwords});
      csr_write(axis_out_pkg::ADDR_THRESH, {28'd0, r.thresh});
      // release soft reset, enable and pick the write source
      csr_write(axis_out_pkg::ADDR_CTRL, {29'd0, r.mode, 2'b10});
   endtask

   task automatic cpu_load(input int row);
      int i;
      for (i = 0; i < int'(rows[row].words); i++) begin
         @(posedge clk);
         csr_we    <= 1'b1;
         csr_addr  <= axis_out_pkg::ADDR_DATA;
         csr_wdata <= data_tab[row][i];
         // output is held, so a full FIFO loses the word
         if (words_q.size() < 8) begin
            words_q.push_back(data_tab[row][i]);
         end
      end
      @(posedge clk);
      csr_we   <= 1'b0;
      csr_addr <= axis_out_pkg::ADDR_STATUS;
   endtask

   task automatic stream_load(input int row);
      int idx;
      int cyc;
      idx = 0;
      for (cyc = 0; cyc < 40; cyc++) begin
         @(posedge clk);
         // level equals accepted words while the output is held
         check("sys_tready_o", 32'(sys_tready), 32'(words_q.size() < 8));
         if (sys_tvalid && sys_tready) begin
            words_q.push_back(data_tab[row][idx]);
            idx++;
         end
         if (idx < int'(rows[row].words) && cyc < 39) begin
            sys_tvalid <= ($urandom % 4 != 0);
            sys_tdata  <= data_tab[row][idx];
         end else begin
            sys_tvalid <= 1'b0;
         end
      end
   endtask

   function automatic void build_bytes(input int nwords);
      int w;
      int l;
      logic [31:0] word;
      bytes_q.delete();
      for (w = 0; w < words_q.size(); w++) begin
         word = words_q[w];
         // low lane first, lanes past nwords are padding
         for (l = 0; l < 4; l++) begin
            if (bytes_q.size() < nwords) begin
               bytes_q.push_back(word[8*l +: 8]);
            end
         end
      end
   endfunction

   task automatic idle_watch();
      int i;
      for (i = 0; i < 8; i++) begin
         @(posedge clk);
         check("axis_tvalid_o", 32'(tvalid), 32'(0));
      end
   endtask

   task automatic drain(input row_t r, output int sent);
      sent   = 0;
      tready <= r.stall ? ($urandom % 2 == 1) : 1'b1;
      while (bytes_q.size() > 0 && (r.cut == 8'd0 || sent < int'(r.cut))) begin
         @(posedge clk);
         if (tvalid && tready) begin
            check("axis_tdata_o", 32'(tdata), 32'(bytes_q[0]));
            check("axis_tlast_o", 32'(tlast), 32'(sent + 1 == int'(r.nwords)));
            void'(bytes_q.pop_front());
            sent++;
         end
         tready <= r.stall ? ($urandom % 2 == 1) : 1'b1;
      end
      if (r.cut == 8'd0) begin
         idle_watch();
      end
   endtask

   task automatic abort_frame(input row_t r);
      csr_write(axis_out_pkg::ADDR_CTRL, 32'h1);
      // FIFO clears one cycle after the write
      @(posedge clk);
      check_status(0, r.thresh);
      tready <= 1'b1;
      csr_write(axis_out_pkg::ADDR_CTRL, {29'd0, r.mode, 2'b10});
      idle_watch();
   endtask

   initial begin
      int r;
      int i;
      int sent;
      int row_err;
      void'($urandom(90));
      rst        = 1'b1;
      csr_addr   = axis_out_pkg::ADDR_STATUS;
      csr_wdata  = '0;
      csr_we     = 1'b0;
      sys_tdata  = '0;
      sys_tvalid = 1'b0;
      tready     = 1'b0;
      // mode, nwords, threshold, words, stall, cut after this many bytes
      rows[0] = '{1'b0, 8'd4,  4'd2, 4'd1,  1'b1, 8'd0};
      rows[1] = '{1'b0, 8'd6,  4'd1, 4'd2,  1'b1, 8'd0};
      rows[2] = '{1'b0, 8'd1,  4'd0, 4'd1,  1'b0, 8'd0};
      rows[3] = '{1'b0, 8'd32, 4'd7, 4'd9,  1'b0, 8'd0};
      rows[4] = '{1'b1, 8'd30, 4'd8, 4'd10, 1'b1, 8'd0};
      rows[5] = '{1'b1, 8'd9,  4'd3, 4'd3,  1'b1, 8'd0};
      rows[6] = '{1'b0, 8'd12, 4'd4, 4'd3,  1'b1, 8'd5};
      rows[7] = '{1'b0, 8'd6,  4'd2, 4'd2,  1'b1, 8'd0};
      for (r = 0; r < ROWS; r++) begin
         for (i = 0; i < 10; i++) begin
            data_tab[r][i] = $urandom();
         end
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check("axis_tvalid_o", 32'(tvalid), 32'(0));
      check("axis_tlast_o", 32'(tlast), 32'(0));
      check("sys_tready_o", 32'(sys_tready), 32'(0));
      check("interrupt_o", 32'(irq), 32'(1));
      check("status.empty", 32'(csr_rdata[1]), 32'(1));
      check("status.level", 32'(csr_rdata[8 +: axis_out_pkg::LEVEL_W]), 32'(0));
      $display("reset checks done, %0d errors", errors);
      for (r = 0; r < ROWS; r++) begin
         row_err = errors;
         tready <= 1'b0;
         words_q.delete();
         restart(rows[r]);
         if (rows[r].mode) begin
            stream_load(r);
         end else begin
            cpu_load(r);
         end
         check_status(words_q.size(), rows[r].thresh);
         build_bytes(int'(rows[r].nwords));
         drain(rows[r], sent);
         if (rows[r].cut != 8'd0) begin
            abort_frame(rows[r]);
         end
         $display("row %0d mode %0d nwords %0d: %0d words in, %0d bytes out, %0d errors",
                  r, rows[r].mode, rows[r].nwords, words_q.size(), sent, errors - row_err);
      end
      $display("rows %0d, checks %0d, errors %0d", ROWS, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: src/axis_out.sv
// ****************************************************************************
// axis_out top level
// register block, width converting FIFO and AXI-Stream read controller
// ****************************************************************************
`timescale 1ns/100ps

module axis_out (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   // register bus
   input  logic [axis_out_pkg::CSR_AW-1:0]       csr_addr_i,
   input  logic [axis_out_pkg::DATA_W-1:0]       csr_wdata_i,
   input  logic                                  csr_we_i,
   output logic [axis_out_pkg::DATA_W-1:0]       csr_rdata_o,
   // stream input
   input  logic [axis_out_pkg::DATA_W-1:0]       sys_tdata_i,
   input  logic                                  sys_tvalid_i,
   output logic                                  sys_tready_o,
   // stream output
   output logic [axis_out_pkg::TDATA_W-1:0]      axis_tdata_o,
   output logic                                  axis_tvalid_o,
   input  logic                                  axis_tready_i,
   output logic                                  axis_tlast_o,
   output logic                                  interrupt_o
);

   axis_out_pkg::axis_out_cfg_t       cfg;
   axis_out_pkg::fifo_wr_t            wr;
   axis_out_pkg::fifo_stat_t          stat;
   logic                              rd_en;
   logic [axis_out_pkg::TDATA_W-1:0]  rd_data;
   logic                              rd_empty;

   axis_out_csrs u_csrs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_we_i    (csr_we_i),
      .csr_rdata_o (csr_rdata_o),
      .sys_tdata_i (sys_tdata_i),
      .sys_tvalid_i(sys_tvalid_i),
      .sys_tready_o(sys_tready_o),
      .stat_i      (stat),
      .cfg_o       (cfg),
      .wr_o        (wr),
      .interrupt_o (interrupt_o)
   );

   axis_out_fifo u_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .cfg_i     (cfg),
      .wr_i      (wr),
      .rd_en_i   (rd_en),
      .rd_data_o (rd_data),
      .rd_empty_o(rd_empty),
      .stat_o    (stat)
   );

   axis_out_reader u_reader (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg),
      .rd_data_i    (rd_data),
      .rd_empty_i   (rd_empty),
      .rd_en_o      (rd_en),
      .axis_tdata_o (axis_tdata_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tready_i(axis_tready_i),
      .axis_tlast_o (axis_tlast_o)
   );

endmodule

// File: src/axis_out_reader.sv
// ****************************************************************************
// axis_out read controller
// pulls lanes from the FIFO and drives the AXI-Stream master side
// ****************************************************************************
`timescale 1ns/100ps

module axis_out_reader (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  axis_out_pkg::axis_out_cfg_t           cfg_i,
   input  logic [axis_out_pkg::TDATA_W-1:0]      rd_data_i,
   input  logic                                  rd_empty_i,
   output logic                                  rd_en_o,
   output logic [axis_out_pkg::TDATA_W-1:0]      axis_tdata_o,
   output logic                                  axis_tvalid_o,
   input  logic                                  axis_tready_i,
   output logic                                  axis_tlast_o
);

   // state 0 idle, state 1 holding a lane
   logic                              state_q;
   logic                              state_nxt;
   logic [axis_out_pkg::DATA_W-1:0]   count_q;
   logic                              in_frame;

   // count of lanes read so far, lane count_q is on rd_data_i
   assign in_frame = count_q <= cfg_i.nwords;

   always_comb begin
      state_nxt     = state_q;
      rd_en_o       = 1'b0;
      axis_tvalid_o = 1'b0;
      if (!state_q) begin
         if (!rd_empty_i) begin
            rd_en_o   = cfg_i.enable;
            state_nxt = 1'b1;
         end
      end else if (in_frame) begin
         axis_tvalid_o = cfg_i.enable;
         if (axis_tready_i && cfg_i.enable) begin
            if (rd_empty_i) begin
               state_nxt = 1'b0;
            end else begin
               rd_en_o = 1'b1;
            end
         end
      end else begin
         // padding lanes are drained without a handshake
         if (rd_empty_i) begin
            state_nxt = 1'b0;
         end else begin
            rd_en_o = cfg_i.enable;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || cfg_i.soft_reset) begin
         state_q <= 1'b0;
         count_q <= '0;
      end else if (cfg_i.enable) begin
         state_q <= state_nxt;
         if (rd_en_o) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   assign axis_tdata_o = rd_data_i;
   assign axis_tlast_o = (count_q == cfg_i.nwords) & axis_tvalid_o;

   // a stalled beat holds while enable stays set
   a_stall_holds : assert property (@(posedge clk_i) disable iff (rst_i || cfg_i.soft_reset)
      axis_tvalid_o && !axis_tready_i ##1 cfg_i.enable |->
         axis_tvalid_o && $stable(axis_tdata_o));

endmodule

// File: src/axis_out_fifo.sv
// ****************************************************************************
// axis_out FIFO
// synchronous queue, bus words in and stream lanes out, level in words
// ****************************************************************************
`timescale 1ns/100ps

module axis_out_fifo (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  axis_out_pkg::axis_out_cfg_t           cfg_i,
   input  axis_out_pkg::fifo_wr_t                wr_i,
   input  logic                                  rd_en_i,
   output logic [axis_out_pkg::TDATA_W-1:0]      rd_data_o,
   output logic                                  rd_empty_o,
   output axis_out_pkg::fifo_stat_t              stat_o
);

   // word storage
   logic [axis_out_pkg::DATA_W-1:0] mem [axis_out_pkg::FIFO_DEPTH];

   // write pointer counts words, read pointer carries a lane index below
   logic [axis_out_pkg::FIFO_AW:0]                      wr_ptr_q;
   logic [axis_out_pkg::FIFO_AW+axis_out_pkg::LANE_W:0] rd_ptr_q;
   logic [axis_out_pkg::FIFO_AW:0]                      rd_word;
   logic [axis_out_pkg::FIFO_AW-1:0]                    rd_addr;
   logic [axis_out_pkg::LANE_W-1:0]                     rd_lane;
   logic [axis_out_pkg::LEVEL_W-1:0]                    level;
   logic                                                full;
   logic                                                wr_ok;
   logic [axis_out_pkg::TDATA_W-1:0]                    rd_data_q;

   assign rd_word = rd_ptr_q[axis_out_pkg::FIFO_AW+axis_out_pkg::LANE_W:axis_out_pkg::LANE_W];
   assign rd_addr = rd_word[axis_out_pkg::FIFO_AW-1:0];
   assign rd_lane = rd_ptr_q[axis_out_pkg::LANE_W-1:0];

   // a word stays in the level until its last lane is gone
   assign level = wr_ptr_q - rd_word;
   assign full  = level == axis_out_pkg::LEVEL_W'(axis_out_pkg::FIFO_DEPTH);

   // writes into a full queue are lost
   assign wr_ok = wr_i.en & ~full;

   always_ff @(posedge clk_i) begin
      if (rst_i || cfg_i.soft_reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_ok) begin
         mem[wr_ptr_q[axis_out_pkg::FIFO_AW-1:0]] <= wr_i.data;
      end
   end

   // lane 0 leaves first
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr][rd_lane*axis_out_pkg::TDATA_W +: axis_out_pkg::TDATA_W];
      end
   end

   assign rd_data_o    = rd_data_q;
   assign stat_o.full  = full;
   assign stat_o.empty = level == '0;
   assign stat_o.level = level;
   assign rd_empty_o   = stat_o.empty;

   // the reader has to respect the empty flag
   a_no_read_when_empty : assert property (@(posedge clk_i) disable iff (rst_i)
      rd_en_i |-> !rd_empty_o);

endmodule

// File: src/axis_out_csrs.sv
// ****************************************************************************
// axis_out register block
// control, frame length and threshold registers, status read and write steering
// ****************************************************************************
`timescale 1ns/100ps

module axis_out_csrs (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic [axis_out_pkg::CSR_AW-1:0]       csr_addr_i,
   input  logic [axis_out_pkg::DATA_W-1:0]       csr_wdata_i,
   input  logic                                  csr_we_i,
   output logic [axis_out_pkg::DATA_W-1:0]       csr_rdata_o,
   input  logic [axis_out_pkg::DATA_W-1:0]       sys_tdata_i,
   input  logic                                  sys_tvalid_i,
   output logic                                  sys_tready_o,
   input  axis_out_pkg::fifo_stat_t              stat_i,
   output axis_out_pkg::axis_out_cfg_t           cfg_o,
   output axis_out_pkg::fifo_wr_t                wr_o,
   output logic                                  interrupt_o
);

   axis_out_pkg::axis_out_cfg_t cfg_q;
   logic                        cpu_push;
   logic                        sys_push;

   // register writes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (csr_we_i) begin
         case (csr_addr_i)
            axis_out_pkg::ADDR_CTRL: begin
               cfg_q.soft_reset <= csr_wdata_i[0];
               cfg_q.enable     <= csr_wdata_i[1];
               cfg_q.mode       <= csr_wdata_i[2];
            end
            axis_out_pkg::ADDR_NWORDS: begin
               cfg_q.nwords <= csr_wdata_i;
            end
            axis_out_pkg::ADDR_THRESH: begin
               cfg_q.threshold <= csr_wdata_i[axis_out_pkg::LEVEL_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   assign cfg_o = cfg_q;

   // combinational read decode
   always_comb begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         axis_out_pkg::ADDR_CTRL: begin
            csr_rdata_o[2:0] = {cfg_q.mode, cfg_q.enable, cfg_q.soft_reset};
         end
         axis_out_pkg::ADDR_NWORDS: begin
            csr_rdata_o = cfg_q.nwords;
         end
         axis_out_pkg::ADDR_THRESH: begin
            csr_rdata_o[axis_out_pkg::LEVEL_W-1:0] = cfg_q.threshold;
         end
         axis_out_pkg::ADDR_STATUS: begin
            csr_rdata_o[0]                           = stat_i.full;
            csr_rdata_o[1]                           = stat_i.empty;
            csr_rdata_o[8 +: axis_out_pkg::LEVEL_W] = stat_i.level;
         end
         default: begin
         end
      endcase
   end

   // fifo write source follows the mode bit
   assign cpu_push    = csr_we_i & (csr_addr_i == axis_out_pkg::ADDR_DATA) & ~cfg_q.mode;
   assign sys_push    = sys_tvalid_i & cfg_q.mode;
   assign wr_o.en     = cfg_q.enable & (cpu_push | sys_push);
   assign wr_o.data   = cfg_q.mode ? sys_tdata_i : csr_wdata_i;

   assign sys_tready_o = ~stat_i.full & cfg_q.enable & cfg_q.mode;
   assign interrupt_o  = stat_i.level <= cfg_q.threshold;

   // stream input is offered only while a word slot is still free
   a_ready_only_with_room : assert property (@(posedge clk_i) disable iff (rst_i)
      sys_tready_o |-> stat_i.level < axis_out_pkg::LEVEL_W'(axis_out_pkg::FIFO_DEPTH));

endmodule

// File: src/axis_out_pkg.sv
// ****************************************************************************
// axis_out package
// widths, register map and shared structs of the AXI-Stream output block
// ****************************************************************************

package axis_out_pkg;

   // bus and stream widths
   localparam int DATA_W  = 32;
   localparam int TDATA_W = 8;
   localparam int LANES   = DATA_W / TDATA_W;
   localparam int LANE_W  = $clog2(LANES);

   // fifo geometry, counted in bus words
   localparam int FIFO_AW    = 3;
   localparam int FIFO_DEPTH = 2 ** FIFO_AW;
   localparam int LEVEL_W    = FIFO_AW + 1;

   // register map
   localparam int               CSR_AW      = 4;
   localparam logic [CSR_AW-1:0] ADDR_CTRL   = 4'd0;
   localparam logic [CSR_AW-1:0] ADDR_DATA   = 4'd1;
   localparam logic [CSR_AW-1:0] ADDR_NWORDS = 4'd2;
   localparam logic [CSR_AW-1:0] ADDR_THRESH = 4'd3;
   localparam logic [CSR_AW-1:0] ADDR_STATUS = 4'd4;

   typedef struct packed {
      logic               soft_reset;
      logic               enable;
      logic               mode;
      logic [DATA_W-1:0]  nwords;
      logic [LEVEL_W-1:0] threshold;
   } axis_out_cfg_t;

   typedef struct packed {
      logic              en;
      logic [DATA_W-1:0] data;
   } fifo_wr_t;

   typedef struct packed {
      logic               full;
      logic               empty;
      logic [LEVEL_W-1:0] level;
   } fifo_stat_t;

endpackage
